/* rtl/heapPkg.sv */
/*
  Shared sizes, opcode and result enums, and the request, issue and
  response structs of the array heap unit
*/
package heapPkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int AddrBits    = 2;                  // Bits in an array number
  localparam int IndexBits   = 2;                  // Bits in an element index
  localparam int DataBits    = 12;                 // Element width
  localparam int NumArrays   = 4;
  localparam int ArrayLength = 4;                  // Elements per array
  localparam int SizeBits    = 3;                  // Holds a full size of four

  // ------------------------------
  // Opcodes and results
  // ------------------------------
  typedef enum logic [3:0] {
    opAlloc, opFree, opWrite, opRead, opSize, opPush,
    opPop, opAdd, opSub, opAnd, opOr, opXor
  } heapOp_e;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errOutOfBounds, errFull, errEmpty, errNoMemory
  } heapError_e;

  // ------------------------------
  // Transfers
  // ------------------------------
  typedef struct packed {
    heapOp_e               op;
    logic [AddrBits-1:0]   array;
    logic [IndexBits-1:0]  index;
    logic [DataBits-1:0]   data;
  } heapReq_t;

  typedef struct packed {
    heapOp_e               op;
    logic [AddrBits-1:0]   slotArray;              // Array whose storage is used
    logic [IndexBits-1:0]  slotIndex;              // Resolved element slot
    logic [DataBits-1:0]   data;
    heapError_e            error;
    logic [SizeBits-1:0]   value;                  // Allocated number or size
  } heapIssue_t;

  typedef struct packed {
    logic [DataBits-1:0]   data;
    heapError_e            error;
  } heapResp_t;

endpackage

/* rtl/heapCheck.sv */
/*
  First pipeline stage of the array heap unit. Holds allocation flags,
  sizes and the freed-array stack, validates requests, resolves slots
*/
`timescale 1ns/1ps

module heapCheck import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  heapReq_t   req,
  input  logic       reqValid,
  output logic       reqReady,
  output heapIssue_t issue,
  output logic       issueValid,
  input  logic       issueReady
);

  logic                 allocated [NumArrays];     // Array currently in use
  logic [SizeBits-1:0]  sizes     [NumArrays];
  logic [AddrBits-1:0]  freeStack [NumArrays];     // LIFO of freed arrays
  logic [SizeBits-1:0]  freeTop;                   // Entries on the free stack
  logic [SizeBits-1:0]  everAlloc;                 // Arrays handed out so far

  logic                 accept;
  logic                 curAlloc;
  logic [SizeBits-1:0]  curSize;
  logic [AddrBits-1:0]  topIndex;                  // Most recently freed entry
  logic [SizeBits-1:0]  indexPlusOne;
  heapError_e           checkError;
  logic [AddrBits-1:0]  slotArray;
  logic [IndexBits-1:0] slotIndex;
  logic [SizeBits-1:0]  value;
  logic [SizeBits-1:0]  newSize;                   // Size of slotArray afterwards

  assign reqReady     = !issueValid || issueReady;
  assign accept       = reqValid && reqReady;
  assign curAlloc     = allocated[req.array];
  assign curSize      = sizes[req.array];
  assign topIndex     = AddrBits'(freeTop - 1'b1);
  assign indexPlusOne = SizeBits'(req.index) + 1'b1;

  // ------------------------------
  // Request check
  // ------------------------------
  always_comb begin
    checkError = errNone;
    slotArray  = req.array;
    slotIndex  = req.index;
    value      = '0;
    newSize    = curSize;
    case (req.op)
      opAlloc: begin
        if (freeTop != '0) begin
          slotArray = freeStack[topIndex];             // Reuse latest freed
        end else if (everAlloc < SizeBits'(NumArrays)) begin
          slotArray = everAlloc[AddrBits-1:0];         // Fresh array
        end else begin
          checkError = errNoMemory;
        end
        value   = SizeBits'(slotArray);
        newSize = '0;
      end
      opFree, opSize: begin
        if (!curAlloc) checkError = errNotAllocated;
        value = curSize;
      end
      opWrite: begin
        if (!curAlloc) begin
          checkError = errNotAllocated;
        end else if (indexPlusOne > curSize) begin
          newSize = indexPlusOne;                      // Grow to cover index
        end
      end
      opPush: begin
        if (!curAlloc) begin
          checkError = errNotAllocated;
        end else if (curSize == SizeBits'(ArrayLength)) begin
          checkError = errFull;
        end else begin
          slotIndex = curSize[IndexBits-1:0];
          newSize   = curSize + 1'b1;
        end
      end
      opPop: begin
        if (!curAlloc) begin
          checkError = errNotAllocated;
        end else if (curSize == '0) begin
          checkError = errEmpty;
        end else begin
          newSize   = curSize - 1'b1;
          slotIndex = newSize[IndexBits-1:0];          // Last element
        end
      end
      default: begin                                   // Read and element ops
        if (!curAlloc) begin
          checkError = errNotAllocated;
        end else if (SizeBits'(req.index) >= curSize) begin
          checkError = errOutOfBounds;
        end
      end
    endcase
  end

  // ------------------------------
  // Bookkeeping and issue register
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      issueValid <= 1'b0;
      freeTop    <= '0;
      everAlloc  <= '0;
      for (int i = 0; i < NumArrays; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
    end else begin
      if (accept) begin
        issueValid <= 1'b1;
      end else if (issueReady) begin
        issueValid <= 1'b0;                            // Item has left
      end
      if (accept && checkError == errNone) begin
        sizes[slotArray] <= newSize;
        if (req.op == opAlloc) begin
          allocated[slotArray] <= 1'b1;
          if (freeTop != '0) freeTop <= freeTop - 1'b1;
          else everAlloc <= everAlloc + 1'b1;
        end
        if (req.op == opFree) begin
          allocated[req.array] <= 1'b0;
          freeTop              <= freeTop + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept && checkError == errNone && req.op == opFree) begin
      freeStack[freeTop[AddrBits-1:0]] <= req.array;   // Push freed array
    end
    if (accept) begin
      issue.op        <= req.op;
      issue.slotArray <= slotArray;
      issue.slotIndex <= slotIndex;
      issue.data      <= req.data;
      issue.error     <= checkError;
      issue.value     <= value;
    end
  end

endmodule

/* rtl/heapStore.sv */
/*
  Second pipeline stage of the array heap unit. Element storage,
  reads, writes and in-place arithmetic, and the response register
*/
`timescale 1ns/1ps

module heapStore import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  heapIssue_t issue,
  input  logic       issueValid,
  output logic       issueReady,
  output heapResp_t  resp,
  output logic       respValid,
  input  logic       respReady
);

  logic [DataBits-1:0] storage [NumArrays][ArrayLength];  // Arrays in fixed blocks

  logic                issueFire;
  logic [DataBits-1:0] element;                 // Current slot contents
  logic [DataBits-1:0] result;                  // Value written back
  logic                writeEn;
  logic [DataBits-1:0] respData;

  assign issueReady = !respValid || respReady;
  assign issueFire  = issueValid && issueReady;
  assign element    = storage[issue.slotArray][issue.slotIndex];

  // ------------------------------
  // Storage action
  // ------------------------------
  always_comb begin
    writeEn  = 1'b0;
    result   = element;
    respData = '0;
    if (issue.error == errNone) begin
      case (issue.op)
        opAlloc, opSize: respData = DataBits'(issue.value);
        opWrite, opPush: begin
          result   = issue.data;
          writeEn  = 1'b1;
          respData = issue.data;
        end
        opRead, opPop: respData = element;
        opAdd, opSub, opAnd, opOr, opXor: begin
          case (issue.op)
            opAdd:   result = element + issue.data;   // Wraps at twelve bits
            opSub:   result = element - issue.data;
            opAnd:   result = element & issue.data;
            opOr:    result = element | issue.data;
            default: result = element ^ issue.data;
          endcase
          writeEn  = 1'b1;
          respData = result;                            // New value
        end
        default: respData = '0;                         // Free returns nothing
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < NumArrays; a++) begin
        for (int i = 0; i < ArrayLength; i++) begin
          storage[a][i] <= '0;
        end
      end
    end else if (issueFire && writeEn) begin
      storage[issue.slotArray][issue.slotIndex] <= result;
    end
  end

  // ------------------------------
  // Response register
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
    end else if (issueFire) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;                                // Taken by the consumer
    end
  end

  always_ff @(posedge clock) begin
    if (issueFire) begin
      resp.data  <= respData;
      resp.error <= issue.error;
    end
  end

endmodule

/* rtl/heapUnit.sv */
/*
  Array heap unit top level with the check stage feeding the store stage
*/
`timescale 1ns/1ps

module heapUnit import heapPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  heapReq_t  req,
  input  logic      reqValid,
  output logic      reqReady,
  output heapResp_t resp,
  output logic      respValid,
  input  logic      respReady
);

  heapIssue_t issue;                            // Checked request
  logic       issueValid;
  logic       issueReady;

  // ------------------------------
  // Pipeline stages
  // ------------------------------
  heapCheck u_heapCheck (
    .clock      (clock),
    .resetN     (resetN),
    .req        (req),
    .reqValid   (reqValid),
    .reqReady   (reqReady),
    .issue      (issue),
    .issueValid (issueValid),
    .issueReady (issueReady)
  );

  heapStore u_heapStore (
    .clock      (clock),
    .resetN     (resetN),
    .issue      (issue),
    .issueValid (issueValid),
    .issueReady (issueReady),
    .resp       (resp),
    .respValid  (respValid),
    .respReady  (respReady)
  );

endmodule

/* dv/heapUnit_sva.sv */
/*
  Handshake and reset assertions on the array heap unit ports,
  bound to the top level
*/
`timescale 1ns/1ps

module heapUnit_sva import heapPkg::*; (
  input logic      clock,
  input logic      resetN,
  input heapReq_t  req,
  input logic      reqValid,
  input logic      reqReady,
  input heapResp_t resp,
  input logic      respValid,
  input logic      respReady
);

  respHold: assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("response dropped or changed before respReady");

  reqHold: assert property (@(posedge clock) disable iff (!resetN)
    reqValid && !reqReady |=> reqValid && $stable(req))
    else $error("request changed or withdrawn while stalled");

  resetIdle: assert property (@(posedge clock) !resetN |-> !respValid)
    else $error("respValid high during reset");

endmodule

bind heapUnit heapUnit_sva u_heapUnitSva (
  .clock     (clock),
  .resetN    (resetN),
  .req       (req),
  .reqValid  (reqValid),
  .reqReady  (reqReady),
  .resp      (resp),
  .respValid (respValid),
  .respReady (respReady)
);

/* dv/heapTb.sv */
/*
  Testbench for the array heap unit. Clock, reset, reference model,
  check task, directed tests and watchdog
*/
`timescale 1ns/1ps

module heapTb import heapPkg::*; ();

  localparam int WatchdogCycles = 2000;         // Several times the test length

  logic      clock;
  logic      resetN;
  heapReq_t  req;
  logic      reqValid;
  logic      reqReady;
  heapResp_t resp;
  logic      respValid;
  logic      respReady;

  bit                  mAlloc [NumArrays];      // Reference model state
  int                  mSize  [NumArrays];
  int                  mStack [NumArrays];
  int                  mTop;
  int                  mEver;
  logic [DataBits-1:0] mData  [NumArrays][ArrayLength];
  heapResp_t           expQ   [$];              // Expected responses in order
  logic [31:0]         randState = 32'h9515b0af;

  heapUnit u_heapUnit (
    .clock     (clock),
    .resetN    (resetN),
    .req       (req),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .resp      (resp),
    .respValid (respValid),
    .respReady (respReady)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [DataBits-1:0] nextRandData();
    randState = randState * 32'd1664525 + 32'd1013904223;
    return randState[27:16];                    // Upper bits mix better
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic predict(input heapReq_t r, output logic [DataBits-1:0] expData,
                         output heapError_e expErr);
    int a;
    int i;
    int t;
    int slot;
    a       = int'(r.array);
    i       = int'(r.index);
    t       = 0;
    slot    = -1;
    expData = '0;
    expErr  = errNone;
    if (r.op == opAlloc) begin
      if (mTop > 0) begin
        mTop = mTop - 1;
        slot = mStack[mTop];                    // Latest freed first
      end else if (mEver < NumArrays) begin
        slot  = mEver;
        mEver = mEver + 1;
      end
      if (slot < 0) begin
        expErr = errNoMemory;
      end else begin
        mAlloc[slot] = 1'b1;
        mSize[slot]  = 0;
        expData      = DataBits'(slot);
      end
    end else if (!mAlloc[a]) begin
      expErr = errNotAllocated;
    end else begin
      case (r.op)
        opFree: begin
          mAlloc[a]    = 1'b0;
          mStack[mTop] = a;
          mTop         = mTop + 1;
        end
        opWrite: begin
          mData[a][i] = r.data;
          if (i + 1 > mSize[a]) mSize[a] = i + 1;
          expData = r.data;
        end
        opSize: expData = DataBits'(mSize[a]);
        opPush: begin
          if (mSize[a] == ArrayLength) begin
            expErr = errFull;
          end else begin
            mData[a][mSize[a]] = r.data;
            mSize[a]           = mSize[a] + 1;
            expData            = r.data;
          end
        end
        opPop: begin
          if (mSize[a] == 0) begin
            expErr = errEmpty;
          end else begin
            mSize[a] = mSize[a] - 1;
            expData  = mData[a][mSize[a]];
          end
        end
        default: begin                          // Read and element ops
          if (i >= mSize[a]) begin
            expErr = errOutOfBounds;
          end else begin
            case (r.op)
              opAdd:   t = (int'(mData[a][i]) + int'(r.data)) % 4096;
              opSub:   t = (int'(mData[a][i]) - int'(r.data) + 4096) % 4096;
              opAnd:   t = int'(mData[a][i] & r.data);
              opOr:    t = int'(mData[a][i] | r.data);
              opXor:   t = int'(mData[a][i] ^ r.data);
              default: t = int'(mData[a][i]);
            endcase
            mData[a][i] = DataBits'(t);
            expData     = DataBits'(t);
          end
        end
      endcase
    end
  endtask

  // ------------------------------
  // Request and response handling
  // ------------------------------
  task automatic sendOnly(input heapOp_e op, input int arr, input int idx,
                          input logic [DataBits-1:0] data);
    heapReq_t            r;
    heapResp_t           e;
    logic [DataBits-1:0] d;
    heapError_e          er;
    r.op    = op;
    r.array = AddrBits'(arr);
    r.index = IndexBits'(idx);
    r.data  = data;
    @(negedge clock);
    req      = r;
    reqValid = 1'b1;
    @(posedge clock);
    while (!reqReady) @(posedge clock);         // Ready before this edge means transfer
    predict(r, d, er);
    e.data  = d;
    e.error = er;
    expQ.push_back(e);
  endtask

  task automatic takeResp(input heapResp_t got);
    heapResp_t e;
    checkValue("response with no request outstanding", 32'd1, 32'(expQ.size() != 0));
    e = expQ.pop_front();
    checkValue("response error", 32'(e.error), 32'(got.error));
    checkValue("response data", 32'(e.data), 32'(got.data));
  endtask

  task automatic runOp(input heapOp_e op, input int arr, input int idx,
                       input logic [DataBits-1:0] data, output heapResp_t got);
    sendOnly(op, arr, idx, data);
    @(negedge clock);
    reqValid = 1'b0;
    while (!respValid) @(negedge clock);
    got = resp;
    takeResp(got);
    @(posedge clock);                           // Response leaves here
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic testAllocation();
    heapResp_t got;
    for (int k = 0; k < NumArrays; k++) begin
      runOp(opAlloc, 0, 0, 12'h000, got);
      checkValue("alloc number", 32'(k), 32'(got.data));
    end
    runOp(opAlloc, 0, 0, 12'h000, got);
    checkValue("alloc with no array left", 32'(errNoMemory), 32'(got.error));
    runOp(opFree, 2, 0, 12'h000, got);
    runOp(opFree, 0, 0, 12'h000, got);
    runOp(opAlloc, 0, 0, 12'h000, got);
    checkValue("alloc reuses latest freed", 32'd0, 32'(got.data));
    runOp(opAlloc, 0, 0, 12'h000, got);
    checkValue("alloc reuses earlier freed", 32'd2, 32'(got.data));
    runOp(opFree, 2, 0, 12'h000, got);
    runOp(opFree, 2, 0, 12'h000, got);
    checkValue("double free", 32'(errNotAllocated), 32'(got.error));
  endtask

  task automatic testElementAccess();
    heapResp_t           got;
    logic [DataBits-1:0] vals [3];
    for (int k = 0; k < 3; k++) vals[k] = nextRandData();
    runOp(opWrite, 1, 2, vals[2], got);
    runOp(opSize, 1, 0, 12'h000, got);
    checkValue("size after write at index 2", 32'd3, 32'(got.data));
    runOp(opWrite, 1, 0, vals[0], got);
    runOp(opWrite, 1, 1, vals[1], got);
    for (int k = 0; k < 3; k++) begin
      runOp(opRead, 1, k, 12'h000, got);
      checkValue("read back", 32'(vals[k]), 32'(got.data));
    end
    runOp(opRead, 1, 3, 12'h000, got);
    checkValue("read past size", 32'(errOutOfBounds), 32'(got.error));
    runOp(opRead, 2, 0, 12'h000, got);
    checkValue("read of freed array", 32'(errNotAllocated), 32'(got.error));
  endtask

  task automatic testStack();
    heapResp_t           got;
    logic [DataBits-1:0] vals [ArrayLength];
    for (int k = 0; k < ArrayLength; k++) begin
      vals[k] = nextRandData();
      runOp(opPush, 3, 0, vals[k], got);
      checkValue("push data", 32'(vals[k]), 32'(got.data));
    end
    runOp(opPush, 3, 0, nextRandData(), got);
    checkValue("push onto full array", 32'(errFull), 32'(got.error));
    for (int k = ArrayLength - 1; k >= 0; k--) begin
      runOp(opPop, 3, 0, 12'h000, got);
      checkValue("pop order", 32'(vals[k]), 32'(got.data));
    end
    runOp(opPop, 3, 0, 12'h000, got);
    checkValue("pop from empty array", 32'(errEmpty), 32'(got.error));
  endtask

  task automatic testArithmetic();
    heapResp_t got;
    heapResp_t rd;
    heapOp_e   op;
    for (int k = 0; k < ArrayLength; k++) runOp(opWrite, 0, k, nextRandData(), got);
    op = opAdd;
    for (int k = 0; k < 5; k++) begin         // Add, sub, and, or, xor
      runOp(op, 0, k % ArrayLength, nextRandData(), got);
      checkValue("element op result", 32'(mData[0][k % ArrayLength]), 32'(got.data));
      runOp(opRead, 0, k % ArrayLength, 12'h000, rd);
      checkValue("stored result", 32'(mData[0][k % ArrayLength]), 32'(rd.data));
      op = op.next();
    end
  endtask

  task automatic testBackPressure();
    int count;
    count = 0;
    @(negedge clock);
    respReady = 1'b0;
    fork
      begin
        sendOnly(opPush, 3, 0, nextRandData());
        sendOnly(opPush, 3, 0, nextRandData());
        sendOnly(opPush, 3, 0, nextRandData());
        sendOnly(opSize, 3, 0, 12'h000);
        sendOnly(opRead, 3, 1, 12'h000);
        sendOnly(opPop, 3, 0, 12'h000);
        sendOnly(opAdd, 3, 0, nextRandData());
        sendOnly(opRead, 3, 3, 12'h000);      // Past size after the pop
        @(negedge clock);
        reqValid = 1'b0;
      end
      begin
        repeat (6) @(negedge clock);
        checkValue("reqReady under back-pressure", 32'd0, 32'(reqReady));
        respReady = 1'b1;
        while (count < 8) begin
          if (respValid) begin
            takeResp(resp);
            count++;
          end
          @(negedge clock);
        end
      end
    join
    repeat (3) begin
      checkValue("extra response", 32'd0, 32'(respValid));
      @(negedge clock);
    end
    checkValue("missing responses", 32'd0, 32'(expQ.size()));
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    resetN    = 1'b0;
    req       = '0;
    reqValid  = 1'b0;
    respReady = 1'b1;
    mTop      = 0;
    mEver     = 0;
    for (int a = 0; a < NumArrays; a++) begin
      mAlloc[a] = 1'b0;
      mSize[a]  = 0;
      mStack[a] = 0;
      for (int i = 0; i < ArrayLength; i++) mData[a][i] = '0;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    testAllocation();
    testElementAccess();
    testStack();
    testArithmetic();
    testBackPressure();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clock);
    $display("CHECKS FAILED");
    $fatal(1, "Timeout: the tests did not finish within the cycle limit");
  end

endmodule

/* verilog.f */
rtl/heapPkg.sv
rtl/heapCheck.sv
rtl/heapStore.sv
rtl/heapUnit.sv
dv/heapUnit_sva.sv
dv/heapTb.sv

/* Makefile */
TOOL      ?= verilator
TOP       ?= heapTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --timing --assert
SIM_FLAGS ?= --binary -j 0 --Mdir $(BUILD_DIR)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
